//--- spidergon_defines.svh
// sizing macros shared by the spidergon node package and RTL, pulled in with `include
`ifndef SPIDERGON_DEFINES_SVH
`define SPIDERGON_DEFINES_SVH

// nodes on the spidergon ring, numbered 0 up to NUM_NODES-1
`define NUM_NODES 8
// bits needed to name one node of the ring
`define NODE_ID_WIDTH 3

// link ports per node: anticlockwise, clockwise and across
`define NUM_PORTS 3

// virtual channels behind every input port, and the bits to name one
`define NUM_VCS 2
`define VC_ID_WIDTH 1

// a flit is a type field on top of the data field
`define FLIT_DATA_WIDTH 16
`define FLIT_TYPE_WIDTH 2
`define FLIT_WIDTH (`FLIT_TYPE_WIDTH + `FLIT_DATA_WIDTH)

// field positions inside a flit
// the type field sits at the top, the channel bit right under it
`define FLIT_TYPE_LSB 16
`define FLIT_VC_BIT 15
// destination of a head or header, body and tail flits carry payload here
`define FLIT_DEST_LSB 12

// flits that one virtual channel buffer can hold
`define VC_BUFFER_DEPTH 2

`endif

//--- spidergon_pkg.sv
// flit, field and direction types of the spidergon node, used by the RTL and the testbench
`include "spidergon_defines.svh"

package spidergon_pkg;

	// one whole flit, type field on top
	typedef logic [`FLIT_WIDTH-1:0] flit_t;

	// node number on the ring
	typedef logic [`NODE_ID_WIDTH-1:0] node_id_t;

	// channel number and one bit per channel
	typedef logic [`VC_ID_WIDTH-1:0] vc_id_t;
	typedef logic [`NUM_VCS-1:0] vc_mask_t;

	// one bit per link port, indexed by port_dir_t
	typedef logic [`NUM_PORTS-1:0] port_mask_t;

	// header is a single flit packet that carries no payload
	typedef enum logic [`FLIT_TYPE_WIDTH-1:0] {
		FLIT_TAIL   = 2'd0,
		FLIT_HEAD   = 2'd1,
		FLIT_BODY   = 2'd2,
		FLIT_HEADER = 2'd3
	} flit_kind_t;

	// stop means the flit has arrived and leaves on no link
	typedef enum logic [1:0] {
		DIR_ANTICLOCKWISE = 2'd0,
		DIR_CLOCKWISE     = 2'd1,
		DIR_ACROSS        = 2'd2,
		DIR_STOP          = 2'd3
	} port_dir_t;

	// field extraction, so no module repeats the bit positions
	function automatic flit_kind_t flit_kind(input flit_t f);
		return flit_kind_t'(f[`FLIT_TYPE_LSB +: `FLIT_TYPE_WIDTH]);
	endfunction

	function automatic vc_id_t flit_vc(input flit_t f);
		return f[`FLIT_VC_BIT -: `VC_ID_WIDTH];
	endfunction

	// only meaningful on a head or a header
	function automatic node_id_t flit_dest(input flit_t f);
		return f[`FLIT_DEST_LSB +: `NODE_ID_WIDTH];
	endfunction

endpackage

//--- rr_arbiter.sv
// round-robin arbiter with a one-hot grant, used for channel and port selection in the node
`timescale 1ns/1ps

module rr_arbiter
#(
	parameter int N = 2
)
(
	input  logic         clk,
	input  logic         reset,
	input  logic [N-1:0] req,
	input  logic         advance,
	output logic [N-1:0] grant
);

	localparam int PTR_WIDTH = (N > 1) ? $clog2(N) : 1;

	// index of the last requester that was actually served
	logic [PTR_WIDTH-1:0] last;
	// index picked in this cycle and whether anybody asked at all
	logic [PTR_WIDTH-1:0] winner;
	logic                 found;

	// scan starts just after the last winner and wraps around,
	// the first requester met is the one granted
	always_comb
	begin
		int idx;
		grant = '0;
		winner = last;
		found = 1'b0;
		for (int i = 1; i <= N; i++)
		begin
			idx = (int'(last) + i) % N;
			if (!found && req[idx])
			begin
				grant[idx] = 1'b1;
				winner = PTR_WIDTH'(idx);
				found = 1'b1;
			end
		end
	end

	// the pointer only moves when the grant was used,
	// a pick that nobody consumed keeps its priority
	always_ff @(posedge clk)
	begin
		if (reset)
			last <= PTR_WIDTH'(N - 1);
		else if (advance && found)
			last <= winner;
	end

endmodule

//--- vc_fifo.sv
// strict-order flit buffer for one virtual channel, instantiated twice in every input port
`timescale 1ns/1ps
`include "spidergon_defines.svh"

module vc_fifo
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 push,
	input  spidergon_pkg::flit_t push_flit,
	input  logic                 pop,
	output spidergon_pkg::flit_t pop_flit,
	output logic                 empty,
	output logic                 full
);

	localparam int DEPTH = `VC_BUFFER_DEPTH;
	localparam int PTR_WIDTH = $clog2(DEPTH);
	localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

	spidergon_pkg::flit_t   mem [DEPTH];
	logic [PTR_WIDTH-1:0]   rd_ptr;
	logic [PTR_WIDTH-1:0]   wr_ptr;
	logic [COUNT_WIDTH-1:0] count;
	logic                   do_push;
	logic                   do_pop;

	// pointers wrap at the depth, which need not be a power of two
	function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
		return (ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign empty = (count == '0);
	assign full = (count == COUNT_WIDTH'(DEPTH));

	// a pop on an empty buffer is ignored
	assign do_pop = pop && !empty;
	// when full, a push still goes in if a pop frees a slot on the same edge
	assign do_push = push && (!full || do_pop);

	// oldest flit is always visible, the consumer looks before it pops
	assign pop_flit = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= push_flit;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			// push and pop together leave the count where it is
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- input_port.sv
// one link input of the node with its channel buffers, reservations and channel arbitration
`timescale 1ns/1ps
`include "spidergon_defines.svh"

module input_port
(
	input  logic                    clk,
	input  logic                    reset,
	input  spidergon_pkg::flit_t    link_flit,
	input  logic                    link_valid,
	output spidergon_pkg::vc_mask_t vc_ready,
	output spidergon_pkg::vc_mask_t vc_full,
	output logic                    pending,
	output spidergon_pkg::flit_t    head_flit,
	input  logic                    pop
);

	// oldest flit of each channel buffer
	spidergon_pkg::flit_t fifo_flit [`NUM_VCS];

	spidergon_pkg::vc_mask_t push;
	spidergon_pkg::vc_mask_t pop_vc;
	spidergon_pkg::vc_mask_t empty;
	spidergon_pkg::vc_mask_t grant;
	// one bit per channel, set while a packet holds it
	spidergon_pkg::vc_mask_t reserved;
	spidergon_pkg::vc_mask_t head_set;
	spidergon_pkg::vc_mask_t tail_clr;

	spidergon_pkg::vc_id_t     link_vc;
	spidergon_pkg::flit_kind_t link_kind;

	// the channel field picks the buffer directly
	assign link_vc = spidergon_pkg::flit_vc(link_flit);
	assign link_kind = spidergon_pkg::flit_kind(link_flit);

	genvar v;
	for (v = 0; v < `NUM_VCS; v++)
	begin : g_vc
		assign push[v] = link_valid && (link_vc == spidergon_pkg::vc_id_t'(v));

		// only the granted channel drains on a pop
		assign pop_vc[v] = pop && grant[v];

		// a head takes the channel as it is written,
		// a header passes through without holding anything
		assign head_set[v] = push[v] && (link_kind == spidergon_pkg::FLIT_HEAD);

		// the channel is given back once its tail has left the buffer
		assign tail_clr[v] = pop_vc[v] &&
			(spidergon_pkg::flit_kind(fifo_flit[v]) == spidergon_pkg::FLIT_TAIL);

		vc_fifo vc_buf
		(
			.clk       (clk),
			.reset     (reset),
			.push      (push[v]),
			.push_flit (link_flit),
			.pop       (pop_vc[v]),
			.pop_flit  (fifo_flit[v]),
			.empty     (empty[v]),
			.full      (vc_full[v])
		);
	end

	// a head on the same edge as a tail pop wins, the new packet owns the channel
	always_ff @(posedge clk)
	begin
		if (reset)
			reserved <= '0;
		else
			reserved <= (reserved & ~tail_clr) | head_set;
	end

	// upstream may start a new packet only on an unreserved channel
	assign vc_ready = ~reserved;

	// every nonempty channel competes, the grant only rotates on a real pop
	rr_arbiter #(.N(`NUM_VCS)) vc_arb
	(
		.clk     (clk),
		.reset   (reset),
		.req     (~empty),
		.advance (pop),
		.grant   (grant)
	);

	assign pending = |(~empty);

	// grant is one-hot, so at most one channel drives the flit
	always_comb
	begin
		head_flit = '0;
		for (int i = 0; i < `NUM_VCS; i++)
		begin
			if (grant[i])
				head_flit = fifo_flit[i];
		end
	end

endmodule

//--- ejection_unit.sv
// picks one input port per cycle and hands its flit to the processor through a register
`timescale 1ns/1ps
`include "spidergon_defines.svh"

module ejection_unit
(
	input  logic                      clk,
	input  logic                      reset,
	input  spidergon_pkg::port_mask_t pending,
	input  spidergon_pkg::flit_t      port_flit0,
	input  spidergon_pkg::flit_t      port_flit1,
	input  spidergon_pkg::flit_t      port_flit2,
	output spidergon_pkg::port_mask_t pop,
	output spidergon_pkg::flit_t      eject_flit,
	output spidergon_pkg::port_dir_t  eject_port,
	output logic                      eject_valid
);

	spidergon_pkg::port_mask_t grant;
	spidergon_pkg::flit_t      sel_flit;
	spidergon_pkg::port_dir_t  sel_port;
	logic                      any_pending;

	assign any_pending = |pending;

	// the processor never refuses, so every pick is consumed at once
	rr_arbiter #(.N(`NUM_PORTS)) port_arb
	(
		.clk     (clk),
		.reset   (reset),
		.req     (pending),
		.advance (any_pending),
		.grant   (grant)
	);

	// the granted port drops its flit on this same edge
	assign pop = grant;

	// one-hot grant to flit and port number
	always_comb
	begin
		case (grant)
			3'b010:
			begin
				sel_flit = port_flit1;
				sel_port = spidergon_pkg::DIR_CLOCKWISE;
			end
			3'b100:
			begin
				sel_flit = port_flit2;
				sel_port = spidergon_pkg::DIR_ACROSS;
			end
			default:
			begin
				sel_flit = port_flit0;
				sel_port = spidergon_pkg::DIR_ANTICLOCKWISE;
			end
		endcase
	end

	// valid is a one-cycle strobe per flit, flit and port only load with it
	always_ff @(posedge clk)
	begin
		if (reset)
			eject_valid <= 1'b0;
		else
			eject_valid <= any_pending;
	end

	always_ff @(posedge clk)
	begin
		if (any_pending)
		begin
			eject_flit <= sel_flit;
			eject_port <= sel_port;
		end
	end

endmodule

//--- injection_unit.sv
// routes processor flits onto one of the three output links, with wormhole direction hold
`timescale 1ns/1ps
`include "spidergon_defines.svh"

module injection_unit
#(
	parameter spidergon_pkg::node_id_t node_id = '0
)
(
	input  logic                      clk,
	input  logic                      reset,
	input  spidergon_pkg::flit_t      cpu_flit,
	input  logic                      cpu_valid,
	output spidergon_pkg::flit_t      out_flit0,
	output spidergon_pkg::flit_t      out_flit1,
	output spidergon_pkg::flit_t      out_flit2,
	output spidergon_pkg::port_mask_t out_valid
);

	spidergon_pkg::flit_kind_t kind;
	spidergon_pkg::port_dir_t  head_dir;
	spidergon_pkg::port_dir_t  sel_dir;
	// direction of the packet in flight, stop when none is open
	spidergon_pkg::port_dir_t  held_dir;
	spidergon_pkg::port_mask_t hit;
	spidergon_pkg::flit_t      out_q [`NUM_PORTS];

	// spidergon rule on the distance clockwise from this node:
	// a quarter of the ring or less goes clockwise, the same going back goes
	// anticlockwise and everything in between takes the across link
	function automatic spidergon_pkg::port_dir_t route(input spidergon_pkg::node_id_t dest);
		spidergon_pkg::node_id_t rel;
		rel = dest - node_id;
		if (rel == '0)
			return spidergon_pkg::DIR_STOP;
		else if (rel <= `NUM_NODES / 4)
			return spidergon_pkg::DIR_CLOCKWISE;
		else if (rel >= `NUM_NODES - `NUM_NODES / 4)
			return spidergon_pkg::DIR_ANTICLOCKWISE;
		else
			return spidergon_pkg::DIR_ACROSS;
	endfunction

	assign kind = spidergon_pkg::flit_kind(cpu_flit);
	assign head_dir = route(spidergon_pkg::flit_dest(cpu_flit));

	// only a head or header carries a destination, the rest follow the head
	assign sel_dir = (kind == spidergon_pkg::FLIT_HEAD || kind == spidergon_pkg::FLIT_HEADER) ?
		head_dir : held_dir;

	// a header opens no packet, so it leaves the held direction alone
	always_ff @(posedge clk)
	begin
		if (reset)
			held_dir <= spidergon_pkg::DIR_STOP;
		else if (cpu_valid)
		begin
			case (kind)
				spidergon_pkg::FLIT_HEAD: held_dir <= head_dir;
				spidergon_pkg::FLIT_TAIL: held_dir <= spidergon_pkg::DIR_STOP;
				default: held_dir <= held_dir;
			endcase
		end
	end

	// stop matches no port, so such flits never leave
	always_comb
	begin
		for (int p = 0; p < `NUM_PORTS; p++)
			hit[p] = (sel_dir == spidergon_pkg::port_dir_t'(p));
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			out_valid <= '0;
		else
			out_valid <= cpu_valid ? hit : '0;
	end

	// the chosen link loads the flit, the other links keep their old data
	always_ff @(posedge clk)
	begin
		for (int p = 0; p < `NUM_PORTS; p++)
		begin
			if (cpu_valid && hit[p])
				out_q[p] <= cpu_flit;
		end
	end

	assign out_flit0 = out_q[0];
	assign out_flit1 = out_q[1];
	assign out_flit2 = out_q[2];

endmodule

//--- spidergon_node.sv
// one spidergon node: three link inputs feeding the processor, processor flits routed to the links
`timescale 1ns/1ps

module spidergon_node
#(
	parameter spidergon_pkg::node_id_t node_id = '0
)
(
	input  logic                      clk,
	input  logic                      reset,
	input  spidergon_pkg::flit_t      link_flit0,
	input  spidergon_pkg::flit_t      link_flit1,
	input  spidergon_pkg::flit_t      link_flit2,
	input  spidergon_pkg::port_mask_t link_valid,
	output spidergon_pkg::vc_mask_t   vc_ready0,
	output spidergon_pkg::vc_mask_t   vc_ready1,
	output spidergon_pkg::vc_mask_t   vc_ready2,
	output spidergon_pkg::vc_mask_t   vc_full0,
	output spidergon_pkg::vc_mask_t   vc_full1,
	output spidergon_pkg::vc_mask_t   vc_full2,
	input  spidergon_pkg::flit_t      cpu_flit,
	input  logic                      cpu_valid,
	output spidergon_pkg::flit_t      eject_flit,
	output spidergon_pkg::port_dir_t  eject_port,
	output logic                      eject_valid,
	output spidergon_pkg::flit_t      out_flit0,
	output spidergon_pkg::flit_t      out_flit1,
	output spidergon_pkg::flit_t      out_flit2,
	output spidergon_pkg::port_mask_t out_valid
);

	// per port: something buffered, the granted flit, and the pop back from ejection
	spidergon_pkg::port_mask_t pending;
	spidergon_pkg::port_mask_t pop;
	spidergon_pkg::flit_t      head_flit0;
	spidergon_pkg::flit_t      head_flit1;
	spidergon_pkg::flit_t      head_flit2;

	// port 0 is anticlockwise
	input_port in_acw
	(
		.clk(clk), .reset(reset),
		.link_flit(link_flit0), .link_valid(link_valid[0]),
		.vc_ready(vc_ready0), .vc_full(vc_full0),
		.pending(pending[0]), .head_flit(head_flit0), .pop(pop[0])
	);

	// port 1 is clockwise
	input_port in_cw
	(
		.clk(clk), .reset(reset),
		.link_flit(link_flit1), .link_valid(link_valid[1]),
		.vc_ready(vc_ready1), .vc_full(vc_full1),
		.pending(pending[1]), .head_flit(head_flit1), .pop(pop[1])
	);

	// port 2 is the across link
	input_port in_across
	(
		.clk(clk), .reset(reset),
		.link_flit(link_flit2), .link_valid(link_valid[2]),
		.vc_ready(vc_ready2), .vc_full(vc_full2),
		.pending(pending[2]), .head_flit(head_flit2), .pop(pop[2])
	);

	ejection_unit eject
	(
		.clk(clk), .reset(reset),
		.pending(pending),
		.port_flit0(head_flit0), .port_flit1(head_flit1), .port_flit2(head_flit2),
		.pop(pop),
		.eject_flit(eject_flit), .eject_port(eject_port), .eject_valid(eject_valid)
	);

	injection_unit #(.node_id(node_id)) inject
	(
		.clk(clk), .reset(reset),
		.cpu_flit(cpu_flit), .cpu_valid(cpu_valid),
		.out_flit0(out_flit0), .out_flit1(out_flit1), .out_flit2(out_flit2),
		.out_valid(out_valid)
	);

endmodule

//--- spidergon_node_asserts.sv
// protocol checker for the spidergon node, attached to every node instance through bind
`timescale 1ns/1ps

module spidergon_node_asserts
(
	input logic                      clk,
	input logic                      reset,
	input logic                      eject_valid,
	input spidergon_pkg::port_mask_t out_valid,
	input spidergon_pkg::port_mask_t link_valid,
	input spidergon_pkg::flit_t      link_flit0,
	input spidergon_pkg::flit_t      link_flit1,
	input spidergon_pkg::flit_t      link_flit2,
	input spidergon_pkg::vc_mask_t   vc_full0,
	input spidergon_pkg::vc_mask_t   vc_full1,
	input spidergon_pkg::vc_mask_t   vc_full2
);

	// flits written from the links that the processor has not seen yet
	int held;

	always_ff @(posedge clk)
	begin
		if (reset)
			held <= 0;
		else
			held <= held + $countones(link_valid) - int'(eject_valid);
	end

	// a flit can only reach the processor while the node still holds one
	eject_needs_flit: assert property (@(posedge clk) disable iff (reset)
		eject_valid |-> held > 0)
		else $error("eject_valid is high although no input port held a flit");

	// the injection side drives one link at most in any cycle
	single_out_link: assert property (@(posedge clk) disable iff (reset)
		$onehot0(out_valid))
		else $error("more than one out_valid bit is high");

	// upstream nodes must hold off while the named channel buffer is full
	acw_not_full: assert property (@(posedge clk) disable iff (reset)
		link_valid[0] |-> !vc_full0[spidergon_pkg::flit_vc(link_flit0)])
		else $error("flit sent on the anticlockwise link into a full channel");

	cw_not_full: assert property (@(posedge clk) disable iff (reset)
		link_valid[1] |-> !vc_full1[spidergon_pkg::flit_vc(link_flit1)])
		else $error("flit sent on the clockwise link into a full channel");

	across_not_full: assert property (@(posedge clk) disable iff (reset)
		link_valid[2] |-> !vc_full2[spidergon_pkg::flit_vc(link_flit2)])
		else $error("flit sent on the across link into a full channel");

endmodule

bind spidergon_node spidergon_node_asserts node_asserts
(
	.clk(clk), .reset(reset),
	.eject_valid(eject_valid), .out_valid(out_valid),
	.link_valid(link_valid),
	.link_flit0(link_flit0), .link_flit1(link_flit1), .link_flit2(link_flit2),
	.vc_full0(vc_full0), .vc_full1(vc_full1), .vc_full2(vc_full2)
);

//--- tb_spidergon_node.sv
// table-driven testbench for one spidergon node, run as the simulation top with the file list
`timescale 1ns/1ps

module tb_spidergon_node;

	localparam int CLK_PERIOD = 20;
	// cycle budget per table row for the watchdog
	localparam int ROW_CYCLES = 20;

	typedef enum {STEP_INJECT, STEP_LINK, STEP_IDLE} step_kind_t;

	// for link and idle rows expect_val and care are {vc_full, vc_ready} of the port,
	// for inject rows expect_val[2:0] is the expected out_valid
	typedef struct {
		string                name;
		step_kind_t           kind;
		int                   port;
		spidergon_pkg::flit_t flit;
		logic [3:0]           expect_val;
		logic [3:0]           care;
		bit                   with_next;
	} step_t;

	logic                      clk = 1'b0;
	logic                      reset;
	spidergon_pkg::flit_t      link_flit [3];
	spidergon_pkg::port_mask_t link_valid;
	spidergon_pkg::vc_mask_t   vc_ready [3];
	spidergon_pkg::vc_mask_t   vc_full [3];
	spidergon_pkg::flit_t      cpu_flit;
	logic                      cpu_valid;
	spidergon_pkg::flit_t      eject_flit;
	spidergon_pkg::port_dir_t  eject_port;
	logic                      eject_valid;
	spidergon_pkg::flit_t      out_flit [3];
	spidergon_pkg::port_mask_t out_valid;

	step_t steps [$];
	// expected ejections, one queue per port and channel at index port*2+vc
	spidergon_pkg::flit_t sb_q [6][$];
	int errors = 0;
	int err_mark = 0;
	int passed = 0;
	int failed = 0;
	bit table_ready = 1'b0;

	always #(CLK_PERIOD / 2) clk = ~clk;

	spidergon_node #(.node_id(3'd0)) spidergon_node_i
	(
		.clk(clk), .reset(reset),
		.link_flit0(link_flit[0]), .link_flit1(link_flit[1]), .link_flit2(link_flit[2]),
		.link_valid(link_valid),
		.vc_ready0(vc_ready[0]), .vc_ready1(vc_ready[1]), .vc_ready2(vc_ready[2]),
		.vc_full0(vc_full[0]), .vc_full1(vc_full[1]), .vc_full2(vc_full[2]),
		.cpu_flit(cpu_flit), .cpu_valid(cpu_valid),
		.eject_flit(eject_flit), .eject_port(eject_port), .eject_valid(eject_valid),
		.out_flit0(out_flit[0]), .out_flit1(out_flit[1]), .out_flit2(out_flit[2]),
		.out_valid(out_valid)
	);

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("** Error %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	// type on top, then channel, destination and a random 12-bit payload
	function automatic spidergon_pkg::flit_t make_flit(input spidergon_pkg::flit_kind_t kind,
		input logic vc, input logic [2:0] dest);
		return {kind, vc, dest, 12'($urandom)};
	endfunction

	function automatic void add_step(input string name, input step_kind_t kind, input int port,
		input spidergon_pkg::flit_t flit, input logic [3:0] expect_val, input logic [3:0] care,
		input bit with_next);
		step_t s;
		s.name = name;
		s.kind = kind;
		s.port = port;
		s.flit = flit;
		s.expect_val = expect_val;
		s.care = care;
		s.with_next = with_next;
		steps.push_back(s);
	endfunction

	task automatic build_table();
		string kname;
		spidergon_pkg::flit_kind_t kinds [3];
		kinds[0] = spidergon_pkg::FLIT_HEAD;
		kinds[1] = spidergon_pkg::FLIT_BODY;
		kinds[2] = spidergon_pkg::FLIT_TAIL;
		// node 0 headers, rel equals the destination: 1-2 clockwise, 3-5 across, 6-7 anticlockwise
		add_step("route_dest0", STEP_INJECT, 0, make_flit(spidergon_pkg::FLIT_HEADER, 0, 0), 4'b000, 0, 0);
		add_step("route_dest1", STEP_INJECT, 0, make_flit(spidergon_pkg::FLIT_HEADER, 0, 1), 4'b010, 0, 0);
		add_step("route_dest2", STEP_INJECT, 0, make_flit(spidergon_pkg::FLIT_HEADER, 0, 2), 4'b010, 0, 0);
		add_step("route_dest3", STEP_INJECT, 0, make_flit(spidergon_pkg::FLIT_HEADER, 1, 3), 4'b100, 0, 0);
		add_step("route_dest4", STEP_INJECT, 0, make_flit(spidergon_pkg::FLIT_HEADER, 1, 4), 4'b100, 0, 0);
		add_step("route_dest5", STEP_INJECT, 0, make_flit(spidergon_pkg::FLIT_HEADER, 0, 5), 4'b100, 0, 0);
		add_step("route_dest6", STEP_INJECT, 0, make_flit(spidergon_pkg::FLIT_HEADER, 0, 6), 4'b001, 0, 0);
		add_step("route_dest7", STEP_INJECT, 0, make_flit(spidergon_pkg::FLIT_HEADER, 1, 7), 4'b001, 0, 0);
		// a packet for this node is dropped as a whole
		add_step("stop_head", STEP_INJECT, 0, make_flit(spidergon_pkg::FLIT_HEAD, 0, 0), 4'b000, 0, 0);
		add_step("stop_body", STEP_INJECT, 0, make_flit(spidergon_pkg::FLIT_BODY, 0, 2), 4'b000, 0, 0);
		add_step("stop_tail", STEP_INJECT, 0, make_flit(spidergon_pkg::FLIT_TAIL, 0, 2), 4'b000, 0, 0);
		// body and tail bits look like destination 1 but must follow the head across
		add_step("worm_head", STEP_INJECT, 0, make_flit(spidergon_pkg::FLIT_HEAD, 0, 4), 4'b100, 0, 0);
		add_step("worm_body", STEP_INJECT, 0, make_flit(spidergon_pkg::FLIT_BODY, 0, 1), 4'b100, 0, 0);
		add_step("worm_tail", STEP_INJECT, 0, make_flit(spidergon_pkg::FLIT_TAIL, 0, 1), 4'b100, 0, 0);
		// clockwise channel 1 stays reserved from head write until the tail is ejected
		add_step("resv_head", STEP_LINK, 1, make_flit(spidergon_pkg::FLIT_HEAD, 1, 0), 4'b0001, 4'hf, 0);
		add_step("resv_body", STEP_LINK, 1, make_flit(spidergon_pkg::FLIT_BODY, 1, 0), 4'b0001, 4'hf, 0);
		add_step("resv_tail", STEP_LINK, 1, make_flit(spidergon_pkg::FLIT_TAIL, 1, 0), 4'b0001, 4'hf, 0);
		add_step("resv_release", STEP_IDLE, 1, '0, 4'b0011, 4'hf, 0);
		// the last winner is clockwise, so round robin serves across then anticlockwise
		// while clockwise channel 1 collects two flits
		add_step("full_acw_a", STEP_LINK, 0, make_flit(spidergon_pkg::FLIT_HEADER, 0, 0), 0, 0, 1);
		add_step("full_across_a", STEP_LINK, 2, make_flit(spidergon_pkg::FLIT_HEADER, 0, 0), 0, 0, 1);
		add_step("full_cw_a", STEP_LINK, 1, make_flit(spidergon_pkg::FLIT_HEADER, 0, 0), 4'b0011, 4'hf, 0);
		add_step("full_acw_b", STEP_LINK, 0, make_flit(spidergon_pkg::FLIT_HEADER, 0, 0), 0, 0, 1);
		add_step("full_across_b", STEP_LINK, 2, make_flit(spidergon_pkg::FLIT_HEADER, 0, 0), 0, 0, 1);
		add_step("full_cw_head", STEP_LINK, 1, make_flit(spidergon_pkg::FLIT_HEAD, 1, 0), 4'b0001, 4'hf, 0);
		add_step("full_cw_tail", STEP_LINK, 1, make_flit(spidergon_pkg::FLIT_TAIL, 1, 0), 4'b1001, 4'hf, 0);
		add_step("full_release", STEP_IDLE, 1, '0, 4'b0011, 4'hf, 0);
		// all ports and both channels at once, only the ready bit of a fresh head is fixed
		for (int k = 0; k < 3; k++)
		begin
			for (int vc = 0; vc < 2; vc++)
			begin
				for (int p = 0; p < 3; p++)
				begin
					kname = $sformatf("eject_%s_p%0d_vc%0d", kinds[k].name(), p, vc);
					add_step(kname, STEP_LINK, p, make_flit(kinds[k], vc[0], 0), 4'b0000,
						(k == 0) ? (vc == 0 ? 4'b0001 : 4'b0010) : 4'b0000, p != 2);
				end
			end
		end
		for (int p = 0; p < 3; p++)
			add_step($sformatf("eject_drain_p%0d", p), STEP_IDLE, p, '0, 4'b0011, 4'hf, 0);
	endtask

	function automatic int queued_count();
		int n;
		n = 0;
		for (int i = 0; i < 6; i++)
			n += sb_q[i].size();
		return n;
	endfunction

	// upstream rule: never into a full channel, a head only into a ready one
	function automatic bit link_open(input int port, input spidergon_pkg::flit_t flit);
		logic vc;
		vc = flit[15];
		if (vc_full[port][vc])
			return 1'b0;
		if (flit[17:16] == spidergon_pkg::FLIT_HEAD && !vc_ready[port][vc])
			return 1'b0;
		return 1'b1;
	endfunction

	task automatic report_row(input string name);
		if (errors == err_mark)
		begin
			$display("ok      %s", name);
			passed++;
		end
		else
		begin
			$display("failed  %s", name);
			failed++;
		end
		err_mark = errors;
	endtask

	// rows chained with with_next share one clock edge
	task automatic run_group(input int first, input int last);
		bit ok;
		int p;
		ok = 1'b0;
		while (!ok)
		begin
			ok = 1'b1;
			for (int i = first; i <= last; i++)
			begin
				if (steps[i].kind == STEP_LINK && !link_open(steps[i].port, steps[i].flit))
					ok = 1'b0;
			end
			if (!ok)
				@(negedge clk);
		end
		for (int i = first; i <= last; i++)
		begin
			p = steps[i].port;
			case (steps[i].kind)
				STEP_INJECT:
				begin
					cpu_flit = steps[i].flit;
					cpu_valid = 1'b1;
				end
				STEP_LINK:
				begin
					link_flit[p] = steps[i].flit;
					link_valid[p] = 1'b1;
					sb_q[p * 2 + int'(steps[i].flit[15])].push_back(steps[i].flit);
				end
				default:
				begin
					// idle rows wait for every sent flit to reach the processor
					while (queued_count() != 0)
						@(negedge clk);
				end
			endcase
		end
		@(negedge clk);
		for (int i = first; i <= last; i++)
		begin
			p = steps[i].port;
			if (steps[i].kind == STEP_INJECT)
			begin
				check_value({steps[i].name, " out_valid"}, steps[i].expect_val[2:0], out_valid);
				for (int o = 0; o < 3; o++)
				begin
					if (steps[i].expect_val[o])
						check_value({steps[i].name, " out_flit"}, steps[i].flit, out_flit[o]);
				end
			end
			else if (steps[i].care != '0)
				check_value({steps[i].name, " flags"}, steps[i].expect_val & steps[i].care,
					{vc_full[p], vc_ready[p]} & steps[i].care);
			report_row(steps[i].name);
		end
		cpu_valid = 1'b0;
		link_valid = '0;
	endtask

	// eject outputs are sampled before the edge updates them, one flit per strobe
	always @(posedge clk)
	begin
		int idx;
		spidergon_pkg::flit_t exp_flit;
		if (!reset && eject_valid)
		begin
			idx = int'(eject_port) * 2 + int'(eject_flit[15]);
			if (eject_port == spidergon_pkg::DIR_STOP || sb_q[idx].size() == 0)
			begin
				$display("flit %h ejected on port %0d was never sent to that channel",
					eject_flit, eject_port);
				errors++;
			end
			else
			begin
				exp_flit = sb_q[idx].pop_front();
				check_value($sformatf("eject port %0d vc %0d", eject_port, eject_flit[15]),
					exp_flit, eject_flit);
			end
		end
	end

	initial
	begin
		wait (table_ready);
		#((steps.size() + 4) * ROW_CYCLES * CLK_PERIOD);
		$display("watchdog expired before all %0d table rows finished", steps.size());
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial
	begin
		int first;
		int last;
		void'($urandom(32'he881));
		reset = 1'b1;
		cpu_flit = '0;
		cpu_valid = 1'b0;
		link_valid = '0;
		for (int p = 0; p < 3; p++)
			link_flit[p] = '0;
		build_table();
		table_ready = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check_value("reset eject_valid", 0, eject_valid);
		check_value("reset out_valid", 0, out_valid);
		for (int p = 0; p < 3; p++)
		begin
			check_value($sformatf("reset vc_ready%0d", p), 2'b11, vc_ready[p]);
			check_value($sformatf("reset vc_full%0d", p), 2'b00, vc_full[p]);
		end
		report_row("reset_state");
		first = 0;
		while (first < steps.size())
		begin
			last = first;
			while (steps[last].with_next)
				last++;
			run_group(first, last);
			first = last + 1;
		end
		if (queued_count() != 0)
		begin
			$display("%0d sent flits never reached the processor", queued_count());
			errors++;
		end
		$display("tests: %0d passed, %0d failed, %0d errors", passed, failed, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+.
spidergon_pkg.sv
rr_arbiter.sv
vc_fifo.sv
input_port.sv
ejection_unit.sv
injection_unit.sv
spidergon_node.sv
spidergon_node_asserts.sv
tb_spidergon_node.sv
